// ==== logic/radio_io_pkg.sv ====
//--------------------------------------------------------------------------
// slot, channel, gpio and led widths of the daughterboard core
// ATR state codes
//--------------------------------------------------------------------------
package radio_io_pkg;

   localparam int NUM_DBOARDS             = 2;
   localparam int NUM_CHANNELS_PER_DBOARD = 2;
   localparam int NUM_CHANNELS            = NUM_DBOARDS * NUM_CHANNELS_PER_DBOARD;

   localparam int DB_GPIO_WIDTH = 32;                  // daughterboard gpio
   localparam int FP_GPIO_WIDTH = 12;                  // front-panel pins
   localparam int FP_SRC_WIDTH  = 2 * FP_GPIO_WIDTH;   // 2 source bits per pin
   localparam int LED_WIDTH     = 3;                   // {rx, txrx_tx, txrx_rx}
   localparam int MISC_WIDTH    = 32;

   // rx running sits in bit 0 and tx running in bit 1
   localparam int         NUM_ATR_STATES = 4;
   localparam logic [1:0] ATR_IDLE       = 2'd0;
   localparam logic [1:0] ATR_RX         = 2'd1;
   localparam logic [1:0] ATR_TX         = 2'd2;
   localparam logic [1:0] ATR_FDX        = 2'd3;

endpackage

// ==== logic/radio_regs_pkg.sv ====
//--------------------------------------------------------------------------
// settings and readback address map of one daughterboard slot
//--------------------------------------------------------------------------
package radio_regs_pkg;

   localparam int SET_ADDR_WIDTH = 8;
   localparam int SET_DATA_WIDTH = 32;
   localparam int RB_DATA_WIDTH  = 64;

   localparam logic [SET_ADDR_WIDTH-1:0] SR_DB_BASE = 8'd160;

   // settings offsets from SR_DB_BASE
   localparam logic [SET_ADDR_WIDTH-1:0] SR_DB_ATR_IDLE  = 8'd0;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_DB_ATR_RX    = 8'd1;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_DB_ATR_TX    = 8'd2;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_DB_ATR_FDX   = 8'd3;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_DB_DDR       = 8'd4;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_FP_ATR_IDLE  = 8'd8;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_FP_ATR_RX    = 8'd9;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_FP_ATR_TX    = 8'd10;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_FP_ATR_FDX   = 8'd11;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_FP_DDR       = 8'd12;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_LED_ATR_IDLE = 8'd16;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_LED_ATR_RX   = 8'd17;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_LED_ATR_TX   = 8'd18;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_LED_ATR_FDX  = 8'd19;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_MISC_OUT     = 8'd24;

   //-----------------------------------------------------------------------
   // readback
   //-----------------------------------------------------------------------
   localparam logic [SET_ADDR_WIDTH-1:0] RB_DB_BASE = 8'd16;
   localparam logic [SET_ADDR_WIDTH-1:0] RB_GPIO    = 8'd0;   // {db gpio in, fp gpio in}
   localparam logic [SET_ADDR_WIDTH-1:0] RB_MISC    = 8'd1;   // {misc in, misc out}

endpackage

// ==== logic/db_atr_if.sv ====
//--------------------------------------------------------------------------
// ATR register words of one slot, register bank to ATR selector
//--------------------------------------------------------------------------
`timescale 1ns/10ps

interface db_atr_if;
   import radio_io_pkg::*;

   logic [DB_GPIO_WIDTH-1:0] db_atr  [NUM_ATR_STATES];   // indexed by ATR state
   logic [DB_GPIO_WIDTH-1:0] db_ddr;
   logic [FP_GPIO_WIDTH-1:0] fp_atr  [NUM_ATR_STATES];
   logic [FP_GPIO_WIDTH-1:0] fp_ddr;
   logic [LED_WIDTH-1:0]     led_atr [NUM_ATR_STATES];

   modport regs (output db_atr, db_ddr, fp_atr, fp_ddr, led_atr);
   modport sel  (input  db_atr, db_ddr, fp_atr, fp_ddr, led_atr);

endinterface

// ==== logic/db_settings_regs.sv ====
//--------------------------------------------------------------------------
// settings decode and ATR register bank of one slot
// misc in and out registers, readback mux
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module db_settings_regs (
   input  logic                                      radio_clk,
   input  logic                                      i_rst,
   input  logic                                      i_set_stb,
   input  logic [radio_regs_pkg::SET_ADDR_WIDTH-1:0] i_set_addr,
   input  logic [radio_regs_pkg::SET_DATA_WIDTH-1:0] i_set_data,
   input  logic [radio_regs_pkg::SET_ADDR_WIDTH-1:0] i_rb_addr,
   input  logic [radio_io_pkg::DB_GPIO_WIDTH-1:0]    i_db_gpio_in,
   input  logic [radio_io_pkg::FP_GPIO_WIDTH-1:0]    i_fp_gpio_in,
   input  logic [radio_io_pkg::MISC_WIDTH-1:0]       i_misc_in,
   output logic                                      o_rb_stb,
   output logic [radio_regs_pkg::RB_DATA_WIDTH-1:0]  o_rb_data,
   output logic [radio_io_pkg::MISC_WIDTH-1:0]       o_misc_out,
   db_atr_if.regs                                    atr
);
   import radio_io_pkg::*;
   import radio_regs_pkg::*;

   logic [SET_ADDR_WIDTH-1:0] set_offset;
   logic [MISC_WIDTH-1:0]     misc_out_reg;
   logic [MISC_WIDTH-1:0]     misc_in_r;
   logic [RB_DATA_WIDTH-1:0]  rb_mux;

   // addresses below the base wrap to offsets far past the map
   assign set_offset = i_set_addr - SR_DB_BASE;

   //-----------------------------------------------------------------------
   // register bank, low offset bits give the ATR state
   //-----------------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         atr.db_atr   <= '{default: '0};
         atr.db_ddr   <= '0;
         atr.fp_atr   <= '{default: '0};
         atr.fp_ddr   <= '0;
         atr.led_atr  <= '{default: '0};
         misc_out_reg <= '0;
      end else if (i_set_stb) begin
         case (set_offset)
            SR_DB_ATR_IDLE, SR_DB_ATR_RX, SR_DB_ATR_TX, SR_DB_ATR_FDX:
               atr.db_atr[set_offset[1:0]] <= i_set_data[DB_GPIO_WIDTH-1:0];
            SR_DB_DDR:
               atr.db_ddr <= i_set_data[DB_GPIO_WIDTH-1:0];
            SR_FP_ATR_IDLE, SR_FP_ATR_RX, SR_FP_ATR_TX, SR_FP_ATR_FDX:
               atr.fp_atr[set_offset[1:0]] <= i_set_data[FP_GPIO_WIDTH-1:0];
            SR_FP_DDR:
               atr.fp_ddr <= i_set_data[FP_GPIO_WIDTH-1:0];
            SR_LED_ATR_IDLE, SR_LED_ATR_RX, SR_LED_ATR_TX, SR_LED_ATR_FDX:
               atr.led_atr[set_offset[1:0]] <= i_set_data[LED_WIDTH-1:0];
            SR_MISC_OUT:
               misc_out_reg <= i_set_data[MISC_WIDTH-1:0];
            default: ;   // unmapped, ignored
         endcase
      end
   end

   // boundary registers for the misc words
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_misc_out <= '0;
         misc_in_r  <= '0;
      end else begin
         o_misc_out <= misc_out_reg;
         misc_in_r  <= i_misc_in;
      end
   end

   //-----------------------------------------------------------------------
   // readback
   //-----------------------------------------------------------------------
   always_comb begin
      case (i_rb_addr)
         RB_DB_BASE + RB_GPIO:
            rb_mux = {i_db_gpio_in, {(RB_DATA_WIDTH/2-FP_GPIO_WIDTH){1'b0}}, i_fp_gpio_in};
         RB_DB_BASE + RB_MISC:
            rb_mux = {misc_in_r, misc_out_reg};
         default:
            rb_mux = '0;
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb <= i_set_stb;             // one pulse per settings strobe
         if (i_set_stb) o_rb_data <= rb_mux;
      end
   end

   // a strobed access must carry a resolved address
   a_set_addr_known : assert property (@(posedge radio_clk) disable iff (i_rst)
      i_set_stb |-> !$isunknown(i_set_addr));

endmodule

// ==== logic/atr_gpio_select.sv ====
//--------------------------------------------------------------------------
// ATR state of one slot and registered gpio, direction and led selection
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module atr_gpio_select (
   input  logic                                             radio_clk,
   input  logic                                             i_rst,
   input  logic [radio_io_pkg::NUM_CHANNELS_PER_DBOARD-1:0] i_run_rx,
   input  logic [radio_io_pkg::NUM_CHANNELS_PER_DBOARD-1:0] i_run_tx,
   db_atr_if.sel                                            atr,
   output logic [radio_io_pkg::DB_GPIO_WIDTH-1:0]           o_db_gpio_out,
   output logic [radio_io_pkg::DB_GPIO_WIDTH-1:0]           o_db_gpio_ddr,
   output logic [radio_io_pkg::FP_GPIO_WIDTH-1:0]           o_fp_gpio_out,
   output logic [radio_io_pkg::FP_GPIO_WIDTH-1:0]           o_fp_gpio_ddr,
   output logic [radio_io_pkg::LED_WIDTH-1:0]               o_led
);
   import radio_io_pkg::*;

   logic       run_rx_any;
   logic       run_tx_any;
   logic [1:0] atr_state;

   // a slot is in rx or tx when either of its channels is
   assign run_rx_any = |i_run_rx;
   assign run_tx_any = |i_run_tx;

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         atr_state <= ATR_IDLE;
      end else begin
         atr_state <= {run_tx_any, run_rx_any};   // tx in bit 1, rx in bit 0
      end
   end

   // word lookup runs one cycle behind the state
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
         o_led         <= '0;
      end else begin
         o_db_gpio_out <= atr.db_atr[atr_state];
         o_db_gpio_ddr <= atr.db_ddr;
         o_fp_gpio_out <= atr.fp_atr[atr_state];
         o_fp_gpio_ddr <= atr.fp_ddr;
         o_led         <= atr.led_atr[atr_state];
      end
   end

   a_state_known : assert property (@(posedge radio_clk) disable iff (i_rst)
      !$isunknown(atr_state));

endmodule

// ==== logic/fp_gpio_src_mux.sv ====
//--------------------------------------------------------------------------
// front-panel source synchronizer and per-pin slot select
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module fp_gpio_src_mux (
   input  logic                                  radio_clk,
   input  logic                                  i_rst,
   input  logic [radio_io_pkg::FP_SRC_WIDTH-1:0] i_fp_gpio_src,
   input  logic [radio_io_pkg::FP_GPIO_WIDTH-1:0] i_fp_out_slot [radio_io_pkg::NUM_DBOARDS],
   input  logic [radio_io_pkg::FP_GPIO_WIDTH-1:0] i_fp_ddr_slot [radio_io_pkg::NUM_DBOARDS],
   output logic [radio_io_pkg::FP_GPIO_WIDTH-1:0] o_fp_gpio_out,
   output logic [radio_io_pkg::FP_GPIO_WIDTH-1:0] o_fp_gpio_ddr
);
   import radio_io_pkg::*;

   logic [FP_SRC_WIDTH-1:0]  src_meta;
   logic [FP_SRC_WIDTH-1:0]  src_sync;
   logic [FP_GPIO_WIDTH-1:0] pin_sel;        // set where slot 1 owns the pin
   logic [FP_GPIO_WIDTH-1:0] pin_reserved;

   // quasi-static word, two flops are enough
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         src_meta <= '0;
         src_sync <= '0;
      end else begin
         src_meta <= i_fp_gpio_src;
         src_sync <= src_meta;
      end
   end

   for (genvar i = 0; i < FP_GPIO_WIDTH; i++) begin : g_pin
      assign pin_sel[i]      = |src_sync[2*i +: 2];   // any nonzero code picks slot 1
      assign pin_reserved[i] = src_sync[2*i+1];
   end

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end else begin
         o_fp_gpio_out <= (i_fp_out_slot[1] & pin_sel) | (i_fp_out_slot[0] & ~pin_sel);
         o_fp_gpio_ddr <= (i_fp_ddr_slot[1] & pin_sel) | (i_fp_ddr_slot[0] & ~pin_sel);
      end
   end

   // codes 2 and 3 are reserved for sources that do not exist yet
   a_no_reserved_code : assert property (@(posedge radio_clk) disable iff (i_rst)
      pin_reserved == '0);

endmodule

// ==== logic/radio_core.sv ====
//--------------------------------------------------------------------------
// radio-clock side of the dual-slot daughterboard core
// two slot register banks, ATR selectors and the front-panel mux
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module radio_core (
   input  logic                                      radio_clk,
   input  logic                                      i_rst,
   // slot 0
   input  logic                                      i_set_stb_0,
   input  logic [radio_regs_pkg::SET_ADDR_WIDTH-1:0] i_set_addr_0,
   input  logic [radio_regs_pkg::SET_DATA_WIDTH-1:0] i_set_data_0,
   input  logic [radio_regs_pkg::SET_ADDR_WIDTH-1:0] i_rb_addr_0,
   output logic                                      o_rb_stb_0,
   output logic [radio_regs_pkg::RB_DATA_WIDTH-1:0]  o_rb_data_0,
   input  logic [radio_io_pkg::DB_GPIO_WIDTH-1:0]    i_db_gpio_in_0,
   output logic [radio_io_pkg::DB_GPIO_WIDTH-1:0]    o_db_gpio_out_0,
   output logic [radio_io_pkg::DB_GPIO_WIDTH-1:0]    o_db_gpio_ddr_0,
   output logic [radio_io_pkg::LED_WIDTH-1:0]        o_radio_led_0,
   input  logic [radio_io_pkg::MISC_WIDTH-1:0]       i_misc_in_0,
   output logic [radio_io_pkg::MISC_WIDTH-1:0]       o_misc_out_0,
   // slot 1
   input  logic                                      i_set_stb_1,
   input  logic [radio_regs_pkg::SET_ADDR_WIDTH-1:0] i_set_addr_1,
   input  logic [radio_regs_pkg::SET_DATA_WIDTH-1:0] i_set_data_1,
   input  logic [radio_regs_pkg::SET_ADDR_WIDTH-1:0] i_rb_addr_1,
   output logic                                      o_rb_stb_1,
   output logic [radio_regs_pkg::RB_DATA_WIDTH-1:0]  o_rb_data_1,
   input  logic [radio_io_pkg::DB_GPIO_WIDTH-1:0]    i_db_gpio_in_1,
   output logic [radio_io_pkg::DB_GPIO_WIDTH-1:0]    o_db_gpio_out_1,
   output logic [radio_io_pkg::DB_GPIO_WIDTH-1:0]    o_db_gpio_ddr_1,
   output logic [radio_io_pkg::LED_WIDTH-1:0]        o_radio_led_1,
   input  logic [radio_io_pkg::MISC_WIDTH-1:0]       i_misc_in_1,
   output logic [radio_io_pkg::MISC_WIDTH-1:0]       o_misc_out_1,
   // channel running flags, channels 2s and 2s+1 belong to slot s
   input  logic [radio_io_pkg::NUM_CHANNELS-1:0]     i_run_rx,
   input  logic [radio_io_pkg::NUM_CHANNELS-1:0]     i_run_tx,
   // front panel
   input  logic [radio_io_pkg::FP_GPIO_WIDTH-1:0]    i_fp_gpio_in,
   output logic [radio_io_pkg::FP_GPIO_WIDTH-1:0]    o_fp_gpio_out,
   output logic [radio_io_pkg::FP_GPIO_WIDTH-1:0]    o_fp_gpio_ddr,
   input  logic [radio_io_pkg::FP_SRC_WIDTH-1:0]     i_fp_gpio_src
);
   import radio_io_pkg::*;

   logic [FP_GPIO_WIDTH-1:0] fp_out_slot [NUM_DBOARDS];   // per-slot candidates
   logic [FP_GPIO_WIDTH-1:0] fp_ddr_slot [NUM_DBOARDS];

   db_atr_if atr_0 ();
   db_atr_if atr_1 ();

   //-----------------------------------------------------------------------
   // slot 0
   //-----------------------------------------------------------------------
   db_settings_regs u_regs_0 (
      .radio_clk, .i_rst,
      .i_set_stb(i_set_stb_0), .i_set_addr(i_set_addr_0), .i_set_data(i_set_data_0),
      .i_rb_addr(i_rb_addr_0), .i_db_gpio_in(i_db_gpio_in_0), .i_fp_gpio_in,
      .i_misc_in(i_misc_in_0), .o_rb_stb(o_rb_stb_0), .o_rb_data(o_rb_data_0),
      .o_misc_out(o_misc_out_0), .atr(atr_0)
   );

   atr_gpio_select u_sel_0 (
      .radio_clk, .i_rst,
      .i_run_rx(i_run_rx[0 +: NUM_CHANNELS_PER_DBOARD]),
      .i_run_tx(i_run_tx[0 +: NUM_CHANNELS_PER_DBOARD]),
      .atr(atr_0), .o_db_gpio_out(o_db_gpio_out_0), .o_db_gpio_ddr(o_db_gpio_ddr_0),
      .o_fp_gpio_out(fp_out_slot[0]), .o_fp_gpio_ddr(fp_ddr_slot[0]), .o_led(o_radio_led_0)
   );

   //-----------------------------------------------------------------------
   // slot 1
   //-----------------------------------------------------------------------
   db_settings_regs u_regs_1 (
      .radio_clk, .i_rst,
      .i_set_stb(i_set_stb_1), .i_set_addr(i_set_addr_1), .i_set_data(i_set_data_1),
      .i_rb_addr(i_rb_addr_1), .i_db_gpio_in(i_db_gpio_in_1), .i_fp_gpio_in,
      .i_misc_in(i_misc_in_1), .o_rb_stb(o_rb_stb_1), .o_rb_data(o_rb_data_1),
      .o_misc_out(o_misc_out_1), .atr(atr_1)
   );

   atr_gpio_select u_sel_1 (
      .radio_clk, .i_rst,
      .i_run_rx(i_run_rx[NUM_CHANNELS_PER_DBOARD +: NUM_CHANNELS_PER_DBOARD]),
      .i_run_tx(i_run_tx[NUM_CHANNELS_PER_DBOARD +: NUM_CHANNELS_PER_DBOARD]),
      .atr(atr_1), .o_db_gpio_out(o_db_gpio_out_1), .o_db_gpio_ddr(o_db_gpio_ddr_1),
      .o_fp_gpio_out(fp_out_slot[1]), .o_fp_gpio_ddr(fp_ddr_slot[1]), .o_led(o_radio_led_1)
   );

   // pin ownership between the slots
   fp_gpio_src_mux u_fp_mux (
      .radio_clk, .i_rst, .i_fp_gpio_src,
      .i_fp_out_slot(fp_out_slot), .i_fp_ddr_slot(fp_ddr_slot),
      .o_fp_gpio_out, .o_fp_gpio_ddr
   );

endmodule

// ==== sim/tb_radio_core.sv ====
//--------------------------------------------------------------------------
// directed testbench for the radio-clock daughterboard core
// clock, reset, stimulus tasks, compare tasks and watchdog
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module tb_radio_core;
   import radio_io_pkg::*;
   import radio_regs_pkg::*;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 5;
   localparam int ATR_STEPS    = 7;

   // cycles spent by each test, plus slack
   localparam int CYC_ATR_SELECT = 3 * NUM_ATR_STATES + 3 * ATR_STEPS;
   localparam int CYC_DDR_MISC   = 4;
   localparam int CYC_READBACK   = 2 * (1 + 3 * 2);
   localparam int CYC_FP_OWNER   = 4 + 2 + 2 * 3 + 3;
   localparam int CYC_MARGIN     = 50;
   localparam int WATCHDOG_NS    = (RESET_CYCLES + CYC_ATR_SELECT + CYC_DDR_MISC
                                    + CYC_READBACK + CYC_FP_OWNER + CYC_MARGIN) * CLK_PERIOD;

   logic                      radio_clk;
   logic                      i_rst;
   logic                      i_set_stb_0, i_set_stb_1;
   logic [SET_ADDR_WIDTH-1:0] i_set_addr_0, i_set_addr_1;
   logic [SET_DATA_WIDTH-1:0] i_set_data_0, i_set_data_1;
   logic [SET_ADDR_WIDTH-1:0] i_rb_addr_0, i_rb_addr_1;
   logic                      o_rb_stb_0, o_rb_stb_1;
   logic [RB_DATA_WIDTH-1:0]  o_rb_data_0, o_rb_data_1;
   logic [DB_GPIO_WIDTH-1:0]  i_db_gpio_in_0, i_db_gpio_in_1;
   logic [DB_GPIO_WIDTH-1:0]  o_db_gpio_out_0, o_db_gpio_out_1;
   logic [DB_GPIO_WIDTH-1:0]  o_db_gpio_ddr_0, o_db_gpio_ddr_1;
   logic [LED_WIDTH-1:0]      o_radio_led_0, o_radio_led_1;
   logic [MISC_WIDTH-1:0]     i_misc_in_0, i_misc_in_1;
   logic [MISC_WIDTH-1:0]     o_misc_out_0, o_misc_out_1;
   logic [NUM_CHANNELS-1:0]   i_run_rx, i_run_tx;
   logic [FP_GPIO_WIDTH-1:0]  i_fp_gpio_in, o_fp_gpio_out, o_fp_gpio_ddr;
   logic [FP_SRC_WIDTH-1:0]   i_fp_gpio_src;

   integer                    seed;
   int                        errors;
   int                        checks;
   logic [MISC_WIDTH-1:0]     misc_out_model [NUM_DBOARDS];   // last misc word per slot

   radio_core uut (.*);

   initial begin
      radio_clk = 1'b0;
      forever #(CLK_PERIOD/2) radio_clk = ~radio_clk;
   end

   //-----------------------------------------------------------------------
   // compare tasks
   //-----------------------------------------------------------------------
   task automatic check_gpio(input string test, input string what,
                             input logic [DB_GPIO_WIDTH-1:0] exp,
                             input logic [DB_GPIO_WIDTH-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s %s: expected %h, actual %h", test, what, exp, act);
      end
   endtask

   task automatic check_fp(input string test, input string what,
                           input logic [FP_GPIO_WIDTH-1:0] exp,
                           input logic [FP_GPIO_WIDTH-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s %s: expected %h, actual %h", test, what, exp, act);
      end
   endtask

   task automatic check_led(input string test, input string what,
                            input logic [LED_WIDTH-1:0] exp,
                            input logic [LED_WIDTH-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s %s: expected %b, actual %b", test, what, exp, act);
      end
   endtask

   task automatic check_misc(input string test, input string what,
                             input logic [MISC_WIDTH-1:0] exp,
                             input logic [MISC_WIDTH-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s %s: expected %h, actual %h", test, what, exp, act);
      end
   endtask

   task automatic check_rb(input string test, input string what,
                           input logic [RB_DATA_WIDTH-1:0] exp,
                           input logic [RB_DATA_WIDTH-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s %s: expected %h, actual %h", test, what, exp, act);
      end
   endtask

   //-----------------------------------------------------------------------
   // bus helpers, called and returning at a falling edge
   //-----------------------------------------------------------------------
   task automatic wait_cycles(input int n);
      repeat (n) @(negedge radio_clk);
   endtask

   task automatic drive_set_bus(input int slot, input logic stb,
                                input logic [SET_ADDR_WIDTH-1:0] addr,
                                input logic [SET_DATA_WIDTH-1:0] data,
                                input logic [SET_ADDR_WIDTH-1:0] rb_addr);
      if (slot == 0) begin
         i_set_stb_0  = stb;
         i_set_addr_0 = addr;
         i_set_data_0 = data;
         i_rb_addr_0  = rb_addr;
      end else begin
         i_set_stb_1  = stb;
         i_set_addr_1 = addr;
         i_set_data_1 = data;
         i_rb_addr_1  = rb_addr;
      end
   endtask

   task automatic write_reg(input int slot, input logic [SET_ADDR_WIDTH-1:0] offset,
                            input logic [SET_DATA_WIDTH-1:0] data);
      drive_set_bus(slot, 1'b1, SR_DB_BASE + offset, data, '0);
      @(negedge radio_clk);
      drive_set_bus(slot, 1'b0, '0, '0, '0);
   endtask

   // strobe with a settings address outside the map, so only readback happens
   task automatic read_back(input int slot, input logic [SET_ADDR_WIDTH-1:0] rb_addr,
                            input logic [RB_DATA_WIDTH-1:0] exp);
      drive_set_bus(slot, 1'b1, 8'h00, '0, rb_addr);
      @(negedge radio_clk);
      drive_set_bus(slot, 1'b0, '0, '0, '0);
      if (((slot == 0) ? o_rb_stb_0 : o_rb_stb_1) !== 1'b1) begin
         errors++;
         $display("readback strobe of slot %0d did not pulse after its settings strobe", slot);
      end
      check_rb("readback", "rb_data", exp, (slot == 0) ? o_rb_data_0 : o_rb_data_1);
      @(negedge radio_clk);
      if (((slot == 0) ? o_rb_stb_0 : o_rb_stb_1) !== 1'b0) begin
         errors++;
         $display("readback strobe of slot %0d stayed high for more than one cycle", slot);
      end
      check_rb("readback", "rb_data held", exp, (slot == 0) ? o_rb_data_0 : o_rb_data_1);
   endtask

   //-----------------------------------------------------------------------
   // tests
   //-----------------------------------------------------------------------
   task automatic reset_values();
      check_gpio("reset_values", "db_out_0", '0, o_db_gpio_out_0);
      check_gpio("reset_values", "db_out_1", '0, o_db_gpio_out_1);
      check_gpio("reset_values", "db_ddr_0", '0, o_db_gpio_ddr_0);
      check_gpio("reset_values", "db_ddr_1", '0, o_db_gpio_ddr_1);
      check_led("reset_values", "led_0", '0, o_radio_led_0);
      check_led("reset_values", "led_1", '0, o_radio_led_1);
      check_fp("reset_values", "fp_out", '0, o_fp_gpio_out);
      check_fp("reset_values", "fp_ddr", '0, o_fp_gpio_ddr);
      check_misc("reset_values", "misc_out_0", '0, o_misc_out_0);
      check_misc("reset_values", "misc_out_1", '0, o_misc_out_1);
      if (o_rb_stb_0 !== 1'b0 || o_rb_stb_1 !== 1'b0) begin
         errors++;
         $display("a readback strobe is not low after reset");
      end
   endtask

   // slot 0 walks its channels through every ATR state, slot 1 stays idle at zero
   task automatic atr_select();
      logic [DB_GPIO_WIDTH-1:0]  db_words  [NUM_ATR_STATES];
      logic [SET_DATA_WIDTH-1:0] fp_raw    [NUM_ATR_STATES];
      logic [SET_DATA_WIDTH-1:0] led_raw   [NUM_ATR_STATES];
      logic [1:0]                rx_pat    [ATR_STEPS];
      logic [1:0]                tx_pat    [ATR_STEPS];
      logic [1:0]                state;
      rx_pat = '{2'b00, 2'b01, 2'b10, 2'b00, 2'b00, 2'b10, 2'b00};
      tx_pat = '{2'b00, 2'b00, 2'b00, 2'b01, 2'b10, 2'b01, 2'b00};
      for (int k = 0; k < NUM_ATR_STATES; k++) begin
         db_words[k] = $random(seed);
         fp_raw[k]   = $random(seed);   // upper bits must be dropped
         led_raw[k]  = $random(seed);
         write_reg(0, SR_DB_ATR_IDLE + k, db_words[k]);
         write_reg(0, SR_FP_ATR_IDLE + k, fp_raw[k]);
         write_reg(0, SR_LED_ATR_IDLE + k, led_raw[k]);
      end
      for (int step = 0; step < ATR_STEPS; step++) begin
         i_run_rx[1:0] = rx_pat[step];
         i_run_tx[1:0] = tx_pat[step];
         if (rx_pat[step] != 0 && tx_pat[step] != 0) state = ATR_FDX;
         else if (tx_pat[step] != 0)                 state = ATR_TX;
         else if (rx_pat[step] != 0)                 state = ATR_RX;
         else                                        state = ATR_IDLE;
         wait_cycles(2);   // state register, then output register
         check_gpio("atr_select", "db_out_0", db_words[state], o_db_gpio_out_0);
         check_led("atr_select", "led_0", led_raw[state][LED_WIDTH-1:0], o_radio_led_0);
         check_gpio("atr_select", "db_out_1", '0, o_db_gpio_out_1);
         check_led("atr_select", "led_1", '0, o_radio_led_1);
         wait_cycles(1);   // front-panel mux stage
         check_fp("atr_select", "fp_out", fp_raw[state][FP_GPIO_WIDTH-1:0], o_fp_gpio_out);
      end
   endtask

   task automatic ddr_and_misc();
      logic [SET_DATA_WIDTH-1:0] db_ddr_raw;
      logic [SET_DATA_WIDTH-1:0] fp_ddr_raw;
      logic [SET_DATA_WIDTH-1:0] misc_raw;
      db_ddr_raw = $random(seed);
      fp_ddr_raw = $random(seed);
      misc_raw   = $random(seed);
      write_reg(1, SR_DB_DDR, db_ddr_raw);
      write_reg(1, SR_FP_DDR, fp_ddr_raw);
      write_reg(1, SR_MISC_OUT, misc_raw);
      misc_out_model[1] = misc_raw;
      wait_cycles(1);
      check_gpio("ddr_and_misc", "db_ddr_1", db_ddr_raw, o_db_gpio_ddr_1);
      check_misc("ddr_and_misc", "misc_out_1", misc_raw, o_misc_out_1);
      check_gpio("ddr_and_misc", "db_ddr_0", '0, o_db_gpio_ddr_0);
      check_misc("ddr_and_misc", "misc_out_0", '0, o_misc_out_0);
      check_fp("ddr_and_misc", "fp_ddr", '0, o_fp_gpio_ddr);   // slot 0 still owns every pin
   endtask

   task automatic readback(input int slot);
      logic [DB_GPIO_WIDTH-1:0] db_in;
      logic [FP_GPIO_WIDTH-1:0] fp_in;
      logic [MISC_WIDTH-1:0]    misc_in;
      db_in   = $random(seed);
      fp_in   = $random(seed);
      misc_in = $random(seed);
      i_fp_gpio_in = fp_in;
      if (slot == 0) begin
         i_db_gpio_in_0 = db_in;
         i_misc_in_0    = misc_in;
      end else begin
         i_db_gpio_in_1 = db_in;
         i_misc_in_1    = misc_in;
      end
      wait_cycles(1);   // misc input register
      read_back(slot, RB_DB_BASE + RB_GPIO, {db_in, 32'(fp_in)});
      read_back(slot, RB_DB_BASE + RB_MISC, {misc_in, misc_out_model[slot]});
      read_back(slot, RB_DB_BASE + 8'd2, '0);
   endtask

   task automatic fp_ownership();
      logic [FP_GPIO_WIDTH-1:0] out_w   [NUM_DBOARDS];
      logic [FP_GPIO_WIDTH-1:0] ddr_w   [NUM_DBOARDS];
      logic [FP_SRC_WIDTH-1:0]  src_pat [2];
      logic [FP_GPIO_WIDTH-1:0] exp_out;
      logic [FP_GPIO_WIDTH-1:0] exp_ddr;
      logic [1:0]               code;
      out_w[0]   = $random(seed);
      out_w[1]   = ~out_w[0];   // every pin differs between the slots
      ddr_w[0]   = $random(seed);
      ddr_w[1]   = ~ddr_w[0];
      src_pat[0] = 24'h444444;  // even pins slot 0, odd pins slot 1
      src_pat[1] = 24'h111111;
      i_run_rx = '0;
      i_run_tx = '0;
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         write_reg(s, SR_FP_ATR_IDLE, out_w[s]);
         write_reg(s, SR_FP_DDR, ddr_w[s]);
      end
      wait_cycles(2);
      check_fp("fp_ownership", "fp_out all slot 0", out_w[0], o_fp_gpio_out);
      check_fp("fp_ownership", "fp_ddr all slot 0", ddr_w[0], o_fp_gpio_ddr);
      for (int p = 0; p < 2; p++) begin
         i_fp_gpio_src = src_pat[p];
         for (int i = 0; i < FP_GPIO_WIDTH; i++) begin
            code       = src_pat[p][2*i +: 2];
            exp_out[i] = (code == 2'd0) ? out_w[0][i] : out_w[1][i];
            exp_ddr[i] = (code == 2'd0) ? ddr_w[0][i] : ddr_w[1][i];
         end
         wait_cycles(3);   // two sync stages and the mux register
         check_fp("fp_ownership", "fp_out", exp_out, o_fp_gpio_out);
         check_fp("fp_ownership", "fp_ddr", exp_ddr, o_fp_gpio_ddr);
      end
      i_fp_gpio_src = '0;
      wait_cycles(3);
   endtask

   //-----------------------------------------------------------------------
   // main sequence and watchdog
   //-----------------------------------------------------------------------
   initial begin
      seed   = 32'h4e69_804c;
      errors = 0;
      checks = 0;
      misc_out_model = '{default: '0};
      i_rst = 1'b1;
      drive_set_bus(0, 1'b0, '0, '0, '0);
      drive_set_bus(1, 1'b0, '0, '0, '0);
      i_db_gpio_in_0 = '0;
      i_db_gpio_in_1 = '0;
      i_misc_in_0    = '0;
      i_misc_in_1    = '0;
      i_run_rx       = '0;
      i_run_tx       = '0;
      i_fp_gpio_in   = '0;
      i_fp_gpio_src  = '0;
      wait_cycles(RESET_CYCLES);
      i_rst = 1'b0;
      reset_values();
      atr_select();
      ddr_and_misc();
      readback(0);
      readback(1);
      fp_ownership();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== radio_core.f ====
logic/radio_io_pkg.sv
logic/radio_regs_pkg.sv
logic/db_atr_if.sv
logic/db_settings_regs.sv
logic/atr_gpio_select.sv
logic/fp_gpio_src_mux.sv
logic/radio_core.sv
sim/tb_radio_core.sv

// ==== Bender.yml ====
package:
  name: radio_core

sources:
  # packages first, then interface and RTL in dependency order
  - logic/radio_io_pkg.sv
  - logic/radio_regs_pkg.sv
  - logic/db_atr_if.sv
  - logic/db_settings_regs.sv
  - logic/atr_gpio_select.sv
  - logic/fp_gpio_src_mux.sv
  - logic/radio_core.sv

  - target: simulation
    files:
      - sim/tb_radio_core.sv
